// ==== source/pipe_types_pkg.sv ====
`default_nettype none

package pipe_types_pkg;

  // Access width of a load or store.
  typedef enum logic [1:0] {
    op_ls_word     = 2'd0,
    op_ls_halfword = 2'd1,
    op_ls_byte     = 2'd2
  } ls_op_t;

  // Where the store operand comes from.
  typedef enum logic {
    fwd_none            = 1'b0,
    fwd_from_memwb_late = 1'b1
  } fwd_t;

endpackage

`default_nettype wire

// ==== source/mem_map_pkg.sv ====
`default_nettype none

package mem_map_pkg;

  // Upper 16 bits select the trickbox window.
  localparam logic [31:0] trickbox_base = 32'hffff_0000;

  // Register offsets inside the window.
  localparam logic [31:0] tb_cycle_offset   = 32'd0;
  localparam logic [31:0] tb_scratch_offset = 32'd4;
  localparam logic [31:0] tb_console_offset = 32'd8;

endpackage

`default_nettype wire

// ==== source/cache_bus_if.sv ====
`default_nettype none

// Level request with waitrequest, one word per access.
interface cache_bus_if #(
  parameter int addr_width = 32
);

  logic                  rd;
  logic                  wr;
  logic [addr_width-1:0] addr;
  logic [31:0]           wr_data;
  logic [3:0]            wr_be;
  logic [31:0]           rd_data;
  logic                  waitrequest;

  modport master (
    output rd, wr, addr, wr_data, wr_be,
    input  rd_data, waitrequest
  );

  modport slave (
    input  rd, wr, addr, wr_data, wr_be,
    output rd_data, waitrequest
  );

endinterface

`default_nettype wire

// ==== source/mem_stage.sv ====
`default_nettype none

module mem_stage import pipe_types_pkg::*; #(
  parameter int addr_width = 32
) (
  input  logic                  clock,
  input  logic                  reset_n,

  cache_bus_if.master           cache,

  input  logic                  load_inst,
  input  logic                  store_inst,
  input  ls_op_t                ls_op,
  input  logic                  ls_sext,
  input  logic [31:0]           alu_result,
  input  logic [31:0]           result_2,
  input  logic [31:0]           result_from_mem_wb,
  input  fwd_t                  b_fwd_from,

  output logic [31:0]           result,
  output logic                  stall,

  output logic [addr_width-1:0] tb_addr,
  output logic                  tb_read,
  output logic                  tb_write,
  output logic [31:0]           tb_data,
  input  logic [31:0]           tb_rdata,
  input  logic                  tb_taken
);

  logic        stall_d1;
  logic [31:0] memwb_retained;
  logic [31:0] word_st;
  logic [1:0]  byte_off;
  logic [31:0] load_word;
  logic [31:0] load_result;
  logic [7:0]  lane_byte;
  logic [15:0] lane_half;

  // ########################################
  // Store data selection and retention
  // ########################################

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      stall_d1 <= 1'b0;
    end else begin
      stall_d1 <= stall;
    end
  end

  // Captured on the first stalled cycle only.
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      memwb_retained <= 32'd0;
    end else if (stall && !stall_d1) begin
      memwb_retained <= result_from_mem_wb;
    end
  end

  always_comb begin
    if (b_fwd_from == fwd_from_memwb_late) begin
      word_st = stall_d1 ? memwb_retained : result_from_mem_wb;
    end else begin
      word_st = result_2;
    end
  end

  assign byte_off = alu_result[1:0];

  // ########################################
  // Routing between trickbox and cache
  // ########################################

  assign tb_addr  = alu_result[addr_width-1:0];
  assign tb_read  = load_inst;
  assign tb_write = store_inst;
  assign tb_data  = word_st;

  assign cache.rd   = load_inst && !tb_taken;
  assign cache.wr   = store_inst && !tb_taken;
  assign cache.addr = {2'b00, alu_result[addr_width-1:2]};

  assign stall = cache.waitrequest;

  // Big-endian lanes, offset 0 sits in bits 31:24.
  always_comb begin
    cache.wr_data = word_st;
    cache.wr_be   = 4'b1111;
    case (ls_op)
      op_ls_byte: begin
        cache.wr_data = {4{word_st[7:0]}};
        cache.wr_be   = 4'b1000 >> byte_off;
      end
      op_ls_halfword: begin
        cache.wr_data = {2{word_st[15:0]}};
        cache.wr_be   = byte_off[1] ? 4'b0011 : 4'b1100;
      end
      default: ;
    endcase
  end

  // ########################################
  // Load steering and extension
  // ########################################

  assign load_word = tb_taken ? tb_rdata : cache.rd_data;

  always_comb begin
    case (byte_off)
      2'd0:    lane_byte = load_word[31:24];
      2'd1:    lane_byte = load_word[23:16];
      2'd2:    lane_byte = load_word[15:8];
      default: lane_byte = load_word[7:0];
    endcase
    lane_half = byte_off[1] ? load_word[15:0] : load_word[31:16];
  end

  always_comb begin
    case (ls_op)
      op_ls_byte:
        load_result = {{24{ls_sext && lane_byte[7]}}, lane_byte};
      op_ls_halfword:
        load_result = {{16{ls_sext && lane_half[15]}}, lane_half};
      default:
        load_result = load_word;
    endcase
  end

  // Non-memory instructions pass the ALU result through.
  assign result = load_inst ? load_result : alu_result;

endmodule

`default_nettype wire

// ==== source/trickbox.sv ====
`default_nettype none

module trickbox import mem_map_pkg::*; #(
  parameter int addr_width = 32
) (
  input  logic                  clock,
  input  logic                  reset_n,

  input  logic [addr_width-1:0] addr,
  input  logic                  read,
  input  logic                  write,
  input  logic [31:0]           data_in,

  output logic [31:0]           data_out,
  output logic                  taken,
  output logic [7:0]            console_data,
  output logic                  console_valid
);

  logic        in_window;
  logic [15:0] offset;
  logic        wr_access;
  logic [31:0] cycle_count;
  logic [31:0] scratch;

  assign in_window = addr[addr_width-1:16] == trickbox_base[addr_width-1:16];
  assign offset    = addr[15:0];
  assign taken     = in_window && (read || write);
  assign wr_access = taken && write;

  // Free-running since reset.
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      cycle_count <= 32'd0;
    end else begin
      cycle_count <= cycle_count + 32'd1;
    end
  end

  // Whole word is written, lanes are ignored here.
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      scratch <= 32'd0;
    end else if (wr_access && offset == tb_scratch_offset[15:0]) begin
      scratch <= data_in;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      console_valid <= 1'b0;
    end else begin
      console_valid <= wr_access && offset == tb_console_offset[15:0];
    end
  end

  always_ff @(posedge clock) begin
    if (wr_access && offset == tb_console_offset[15:0]) begin
      console_data <= data_in[7:0];
    end
  end

  // Console and unmapped offsets read as zero.
  always_comb begin
    if (offset == tb_cycle_offset[15:0]) begin
      data_out = cycle_count;
    end else if (offset == tb_scratch_offset[15:0]) begin
      data_out = scratch;
    end else begin
      data_out = 32'd0;
    end
  end

endmodule

`default_nettype wire

// ==== source/data_ram.sv ====
`default_nettype none

module data_ram #(
  parameter int depth_words = 256,
  parameter int wait_cycles = 2
) (
  input  logic       clock,
  input  logic       reset_n,

  cache_bus_if.slave bus
);

  localparam int idx_width = $clog2(depth_words);
  localparam int cnt_width = (wait_cycles > 0) ? $clog2(wait_cycles + 1) : 1;
  localparam logic [cnt_width-1:0] wait_last = cnt_width'(wait_cycles);

  logic [31:0]          mem [depth_words];
  logic [idx_width-1:0] index;
  logic [cnt_width-1:0] wait_count;
  logic                 request;
  logic                 complete;

  // Power-of-two depth, so the slice is the modulo.
  assign index   = bus.addr[idx_width-1:0];
  assign request = bus.rd || bus.wr;

  assign bus.waitrequest = request && (wait_count != wait_last);
  assign complete        = request && !bus.waitrequest;

  // Restarts after every completed access.
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      wait_count <= '0;
    end else if (request && bus.waitrequest) begin
      wait_count <= wait_count + 1'b1;
    end else begin
      wait_count <= '0;
    end
  end

  always_ff @(posedge clock) begin
    if (complete && bus.wr) begin
      if (bus.wr_be[3]) mem[index][31:24] <= bus.wr_data[31:24];
      if (bus.wr_be[2]) mem[index][23:16] <= bus.wr_data[23:16];
      if (bus.wr_be[1]) mem[index][15:8]  <= bus.wr_data[15:8];
      if (bus.wr_be[0]) mem[index][7:0]   <= bus.wr_data[7:0];
    end
  end

  assign bus.rd_data = mem[index];

endmodule

`default_nettype wire

// ==== source/load_store_unit.sv ====
`default_nettype none

module load_store_unit import pipe_types_pkg::*; (
  input  logic        clock,
  input  logic        reset_n,

  input  logic        load_inst,
  input  logic        store_inst,
  input  ls_op_t      ls_op,
  input  logic        ls_sext,
  input  fwd_t        b_fwd_from,
  input  logic [31:0] alu_result,
  input  logic [31:0] result_2,
  input  logic [31:0] result_from_mem_wb,

  output logic [31:0] result,
  output logic        stall,

  output logic [7:0]  console_data,
  output logic        console_valid
);

  localparam int addr_width  = 32;
  localparam int depth_words = 256;
  localparam int wait_cycles = 2;

  logic [addr_width-1:0] tb_addr;
  logic                  tb_read;
  logic                  tb_write;
  logic [31:0]           tb_data;
  logic [31:0]           tb_rdata;
  logic                  tb_taken;

  cache_bus_if #(.addr_width(addr_width)) cache_bus ();

  mem_stage #(
    .addr_width(addr_width)
  ) u_mem_stage (
    .clock             (clock),
    .reset_n           (reset_n),
    .cache             (cache_bus.master),
    .load_inst         (load_inst),
    .store_inst        (store_inst),
    .ls_op             (ls_op),
    .ls_sext           (ls_sext),
    .alu_result        (alu_result),
    .result_2          (result_2),
    .result_from_mem_wb(result_from_mem_wb),
    .b_fwd_from        (b_fwd_from),
    .result            (result),
    .stall             (stall),
    .tb_addr           (tb_addr),
    .tb_read           (tb_read),
    .tb_write          (tb_write),
    .tb_data           (tb_data),
    .tb_rdata          (tb_rdata),
    .tb_taken          (tb_taken)
  );

  trickbox #(
    .addr_width(addr_width)
  ) u_trickbox (
    .clock        (clock),
    .reset_n      (reset_n),
    .addr         (tb_addr),
    .read         (tb_read),
    .write        (tb_write),
    .data_in      (tb_data),
    .data_out     (tb_rdata),
    .taken        (tb_taken),
    .console_data (console_data),
    .console_valid(console_valid)
  );

  data_ram #(
    .depth_words(depth_words),
    .wait_cycles(wait_cycles)
  ) u_data_ram (
    .clock  (clock),
    .reset_n(reset_n),
    .bus    (cache_bus.slave)
  );

endmodule

`default_nettype wire

// ==== tests/load_store_unit_assert.sv ====
`default_nettype none

module load_store_unit_assert import mem_map_pkg::*; (
  input logic        clock,
  input logic        reset_n,
  input logic        load_inst,
  input logic        store_inst,
  input logic [31:0] tb_addr,
  input logic        rd,
  input logic        wr,
  input logic [31:0] addr,
  input logic [31:0] wr_data,
  input logic [3:0]  wr_be,
  input logic        waitrequest,
  input logic        tb_taken
);

  a_rd_wr_exclusive: assert property (
    @(posedge clock) disable iff (!reset_n) !(rd && wr)
  ) else $error("cache rd and wr are high together");

  // Window accesses go to the trickbox and never reach the cache.
  a_taken_no_cache: assert property (
    @(posedge clock) disable iff (!reset_n)
    ((load_inst || store_inst) && tb_addr[31:16] == trickbox_base[31:16])
      |-> (tb_taken && !(rd || wr))
  ) else $error("cache request raised during a trickbox access");

  // Request fields must hold while the RAM waits.
  a_hold_on_wait: assert property (
    @(posedge clock) disable iff (!reset_n)
    ((rd || wr) && waitrequest) |=> ($stable(addr) && $stable(wr_data) && $stable(wr_be))
  ) else $error("cache request changed while waitrequest was high");

endmodule

bind mem_stage load_store_unit_assert u_bus_assert (
  .clock      (clock),
  .reset_n    (reset_n),
  .load_inst  (load_inst),
  .store_inst (store_inst),
  .tb_addr    (tb_addr),
  .rd         (cache.rd),
  .wr         (cache.wr),
  .addr       (cache.addr),
  .wr_data    (cache.wr_data),
  .wr_be      (cache.wr_be),
  .waitrequest(cache.waitrequest),
  .tb_taken   (tb_taken)
);

`default_nettype wire

// ==== tests/load_store_unit_tb.sv ====
`default_nettype none

module load_store_unit_tb import pipe_types_pkg::*, mem_map_pkg::*; ;

  localparam int wait_states   = 2;
  localparam int stall_limit   = 20;
  localparam int console_limit = 10;

  logic        clock;
  logic        reset_n;
  logic        load_inst;
  logic        store_inst;
  ls_op_t      ls_op;
  logic        ls_sext;
  fwd_t        b_fwd_from;
  logic [31:0] alu_result;
  logic [31:0] result_2;
  logic [31:0] result_from_mem_wb;
  logic [31:0] result;
  logic        stall;
  logic [7:0]  console_data;
  logic        console_valid;

  logic [31:0] model_mem [256];
  logic [31:0] lfsr_state;
  int          error_count;

  load_store_unit DUT (
    .clock             (clock),
    .reset_n           (reset_n),
    .load_inst         (load_inst),
    .store_inst        (store_inst),
    .ls_op             (ls_op),
    .ls_sext           (ls_sext),
    .b_fwd_from        (b_fwd_from),
    .alu_result        (alu_result),
    .result_2          (result_2),
    .result_from_mem_wb(result_from_mem_wb),
    .result            (result),
    .stall             (stall),
    .console_data      (console_data),
    .console_valid     (console_valid)
  );

  always #2 clock = ~clock;

  // ########################################
  // Random source and reference model
  // ########################################

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // Offset 0 is the most significant byte.
  function automatic logic [31:0] merge_store(input logic [31:0] old, input ls_op_t op,
                                              input int off, input logic [31:0] data);
    logic [31:0] merged;
    merged = old;
    case (op)
      op_ls_byte:     merged[31 - 8*off -: 8] = data[7:0];
      op_ls_halfword: merged[31 - 8*off -: 16] = data[15:0];
      default:        merged = data;
    endcase
    return merged;
  endfunction

  function automatic logic [31:0] expected_load(input logic [31:0] word, input ls_op_t op,
                                                input int off, input logic sext);
    logic [7:0]  lane8;
    logic [15:0] lane16;
    lane8  = word[31 - 8*off -: 8];
    lane16 = (off >= 2) ? word[15:0] : word[31:16];
    case (op)
      op_ls_byte:     return sext ? 32'($signed(lane8)) : 32'(lane8);
      op_ls_halfword: return sext ? 32'($signed(lane16)) : 32'(lane16);
      default:        return word;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR time %0t %s: got %h expected %h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  // ########################################
  // Bus access helpers
  // ########################################

  // Presents one access and returns result at the completing cycle.
  task automatic mem_access(input logic is_load, input logic is_store, input ls_op_t op,
                            input logic sext, input logic [31:0] addr,
                            input logic [31:0] data, input fwd_t fwd,
                            input logic [31:0] memwb_first, input logic [31:0] memwb_late,
                            output logic [31:0] rdata, output int stalls);
    int waited;
    waited = 0;
    @(posedge clock);
    load_inst          <= is_load;
    store_inst         <= is_store;
    ls_op              <= op;
    ls_sext            <= sext;
    alu_result         <= addr;
    result_2           <= data;
    b_fwd_from         <= fwd;
    result_from_mem_wb <= memwb_first;
    @(negedge clock);
    while (stall && waited < stall_limit) begin
      waited++;
      @(posedge clock);
      result_from_mem_wb <= memwb_late;
      @(negedge clock);
    end
    if (stall) begin
      $display("Timeout at %0t: stall stayed high for %0d cycles", $time, waited);
      error_count++;
    end
    rdata  = result;
    stalls = waited;
    @(posedge clock);
    load_inst  <= 1'b0;
    store_inst <= 1'b0;
  endtask

  task automatic ram_store(input ls_op_t op, input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    int          stalls;
    mem_access(1'b0, 1'b1, op, 1'b0, addr, data, fwd_none, ~data, ~data, rdata, stalls);
    check_value("stall_cycles", stalls, wait_states);
    model_mem[addr[9:2]] = merge_store(model_mem[addr[9:2]], op, int'(addr[1:0]), data);
  endtask

  task automatic ram_load(input ls_op_t op, input logic sext, input logic [31:0] addr);
    logic [31:0] rdata;
    int          stalls;
    mem_access(1'b1, 1'b0, op, sext, addr, 32'd0, fwd_none, 32'd0, 32'd0, rdata, stalls);
    check_value("stall_cycles", stalls, wait_states);
    check_value("result", rdata,
                expected_load(model_mem[addr[9:2]], op, int'(addr[1:0]), sext));
  endtask

  // ########################################
  // Directed tests
  // ########################################

  task automatic word_round_trip();
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] data;
    for (int i = 0; i < 8; i++) begin
      r = random_bits(8);
      addr = {22'd0, r[7:0], 2'b00};
      data = random_bits(32);
      ram_store(op_ls_word, addr, data);
      ram_load(op_ls_word, 1'b0, addr);
    end
  endtask

  task automatic lane_steering();
    logic [31:0] base;
    logic [31:0] data;
    base = 32'h0000_0100;
    ram_store(op_ls_word, base, 32'h8f12_7fe0);
    for (int off = 0; off < 4; off++) begin
      data = random_bits(32);
      ram_store(op_ls_byte, base + off, data);
      ram_load(op_ls_word, 1'b0, base);
    end
    for (int off = 0; off < 4; off += 2) begin
      data = random_bits(32);
      ram_store(op_ls_halfword, base + off, data);
      ram_load(op_ls_word, 1'b0, base);
    end
    // Mixed sign bits in every lane.
    ram_store(op_ls_word, base, 32'h8f12_7fe0);
    for (int off = 0; off < 4; off++) begin
      ram_load(op_ls_byte, 1'b0, base + off);
      ram_load(op_ls_byte, 1'b1, base + off);
    end
    for (int off = 0; off < 4; off += 2) begin
      ram_load(op_ls_halfword, 1'b0, base + off);
      ram_load(op_ls_halfword, 1'b1, base + off);
    end
  endtask

  task automatic late_forwarding();
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] first;
    logic [31:0] late;
    logic [31:0] rdata;
    int          stalls;
    r = random_bits(8);
    addr = {22'd0, r[7:0], 2'b00};
    data = random_bits(32);
    first = random_bits(32);
    late = random_bits(32);
    mem_access(1'b0, 1'b1, op_ls_word, 1'b0, addr, data, fwd_from_memwb_late,
               first, late, rdata, stalls);
    check_value("stall_cycles", stalls, wait_states);
    model_mem[addr[9:2]] = first;
    ram_load(op_ls_word, 1'b0, addr);
    ram_store(op_ls_word, addr, data);
    ram_load(op_ls_word, 1'b0, addr);
  endtask

  task automatic trickbox_registers();
    logic [31:0] data;
    logic [31:0] rdata;
    logic [31:0] first_count;
    int          stalls;
    int          waited;
    data = random_bits(32);
    mem_access(1'b0, 1'b1, op_ls_word, 1'b0, trickbox_base | tb_scratch_offset, data,
               fwd_none, 32'd0, 32'd0, rdata, stalls);
    check_value("stall_cycles", stalls, 0);
    mem_access(1'b1, 1'b0, op_ls_word, 1'b0, trickbox_base | tb_scratch_offset, 32'd0,
               fwd_none, 32'd0, 32'd0, rdata, stalls);
    check_value("stall_cycles", stalls, 0);
    check_value("scratch", rdata, data);

    mem_access(1'b1, 1'b0, op_ls_word, 1'b0, trickbox_base | tb_cycle_offset, 32'd0,
               fwd_none, 32'd0, 32'd0, first_count, stalls);
    check_value("stall_cycles", stalls, 0);
    repeat (5) @(posedge clock);
    mem_access(1'b1, 1'b0, op_ls_word, 1'b0, trickbox_base | tb_cycle_offset, 32'd0,
               fwd_none, 32'd0, 32'd0, rdata, stalls);
    check_value("stall_cycles", stalls, 0);
    if (!(rdata > first_count)) begin
      $display("Cycle counter did not advance: first %0d, second %0d", first_count, rdata);
      error_count++;
    end

    data = random_bits(32);
    mem_access(1'b0, 1'b1, op_ls_word, 1'b0, trickbox_base | tb_console_offset, data,
               fwd_none, 32'd0, 32'd0, rdata, stalls);
    check_value("stall_cycles", stalls, 0);
    waited = 0;
    @(negedge clock);
    while (!console_valid && waited < console_limit) begin
      waited++;
      @(negedge clock);
    end
    if (!console_valid) begin
      $display("Timeout at %0t: console_valid never went high", $time);
      error_count++;
    end else begin
      check_value("console_data", {24'd0, console_data}, {24'd0, data[7:0]});
    end
  endtask

  task automatic alu_passthrough();
    logic [31:0] value;
    for (int i = 0; i < 6; i++) begin
      value = random_bits(32);
      @(posedge clock);
      load_inst  <= 1'b0;
      store_inst <= 1'b0;
      alu_result <= value;
      @(negedge clock);
      check_value("result", result, value);
      check_value("stall", {31'd0, stall}, 32'd0);
    end
  endtask

  initial begin
    clock              = 1'b0;
    reset_n            = 1'b0;
    load_inst          = 1'b0;
    store_inst         = 1'b0;
    ls_op              = op_ls_word;
    ls_sext            = 1'b0;
    b_fwd_from         = fwd_none;
    alu_result         = 32'd0;
    result_2           = 32'd0;
    result_from_mem_wb = 32'd0;
    lfsr_state         = 32'hcc8f;
    error_count        = 0;
    repeat (2) @(posedge clock);
    reset_n <= 1'b1;

    word_round_trip();
    lane_steering();
    late_forwarding();
    trickbox_registers();
    alu_passthrough();

    $display("Errors: %0d", error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/pipe_types_pkg.sv
source/mem_map_pkg.sv
source/cache_bus_if.sv
source/mem_stage.sv
source/trickbox.sv
source/data_ram.sv
source/load_store_unit.sv
tests/load_store_unit_assert.sv
tests/load_store_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the load/store unit simulation with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=load_store_unit_sim
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f \
  --top-module load_store_unit_tb \
  -Mdir "$build_dir" -o "$sim_bin"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$log_file"; then
  exit 0
fi
echo "Pass message not found in $log_file"
exit 1
